//--- include/flight_ctrl_cfg.svh
`ifndef FLIGHT_CTRL_CFG_SVH
`define FLIGHT_CTRL_CFG_SVH

// data word width, Q12.4 two's complement
`define FC_DATA_WIDTH 16

// receiver target width
`define FC_REC_WIDTH 8

// centre offset for yaw, pitch and roll targets
// 500 raw is 31.25 in Q12.4
`define FC_MAP_OFFSET (500)

// throttle upper limit, 60.0
`define FC_THROTTLE_MAX (960)

// symmetric yaw, pitch and roll rate limit, 25.0
`define FC_RATE_MAX (400)

// left shift scale factors
// zero keeps a unity scale
`define FC_YAW_SHIFT (0)
`define FC_PITCH_SHIFT (0)
`define FC_ROLL_SHIFT (0)
`define FC_THROTTLE_SHIFT (0)

// symmetric clamp on each rate error in the mixer, 20.0
`define FC_RATE_ERR_MAX (320)

// upper motor command limit, 100.0
`define FC_MOTOR_MAX (1600)

// averaging depth of the gyro filter as log2
`define FC_GYRO_DEPTH_LOG2 2

`endif

//--- rtl/flight_ctrl_pkg.sv
`default_nettype none

`include "flight_ctrl_cfg.svh"

package flight_ctrl_pkg;

	// signed Q12.4 value shared by rates, angles and motor commands
	typedef logic signed [`FC_DATA_WIDTH-1:0] fixed_t;

	// angle controller sequence in one-hot form
	typedef enum logic [4:0] {
		ANGLE_WAITING  = 5'b00001,
		ANGLE_MAPPING  = 5'b00010,
		ANGLE_SCALING  = 5'b00100,
		ANGLE_LIMITING = 5'b01000,
		ANGLE_COMPLETE = 5'b10000
	} angle_state_e;

endpackage

`default_nettype wire

//--- rtl/angle_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "flight_ctrl_cfg.svh"

module angle_controller (
	input wire us_clk,
	input wire resetn,
	input wire start,
	input wire [`FC_REC_WIDTH-1:0] throttle_target,
	input wire [`FC_REC_WIDTH-1:0] yaw_target,
	input wire [`FC_REC_WIDTH-1:0] pitch_target,
	input wire [`FC_REC_WIDTH-1:0] roll_target,
	input wire flight_ctrl_pkg::fixed_t pitch_actual,
	input wire flight_ctrl_pkg::fixed_t roll_actual,
	output flight_ctrl_pkg::fixed_t throttle_rate,
	output flight_ctrl_pkg::fixed_t yaw_rate,
	output flight_ctrl_pkg::fixed_t pitch_rate,
	output flight_ctrl_pkg::fixed_t roll_rate,
	output flight_ctrl_pkg::fixed_t pitch_angle_error,
	output flight_ctrl_pkg::fixed_t roll_angle_error,
	output logic active,
	output logic complete
);

	// headroom for the scale shifts, up to 8 bits of shift
	localparam int SCALE_W = `FC_DATA_WIDTH + 8;

	typedef logic signed [SCALE_W-1:0] scale_t;

	flight_ctrl_pkg::angle_state_e state, next_state;

	// mapped values, pitch and roll already hold the angle error
	flight_ctrl_pkg::fixed_t mapped_throttle, mapped_yaw, mapped_pitch, mapped_roll;

	// shifted values, kept wide until the limiter
	scale_t scaled_throttle, scaled_yaw, scaled_pitch, scaled_roll;

	// receiver value times four, zero extended
	function automatic flight_ctrl_pkg::fixed_t map_rec(input logic [`FC_REC_WIDTH-1:0] rec);
		return flight_ctrl_pkg::fixed_t'({rec, 2'b00});
	endfunction

	// saturate a wide value into the given range
	function automatic flight_ctrl_pkg::fixed_t sat(input scale_t v, input scale_t lo,
			input scale_t hi);
		if (v > hi)
			return flight_ctrl_pkg::fixed_t'(hi);
		else if (v < lo)
			return flight_ctrl_pkg::fixed_t'(lo);
		else
			return flight_ctrl_pkg::fixed_t'(v);
	endfunction

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= flight_ctrl_pkg::ANGLE_WAITING;
		else
			state <= next_state;
	end

	// sequence advances one state per cycle once started
	always_comb begin
		case (state)
			flight_ctrl_pkg::ANGLE_WAITING:
				next_state = start ? flight_ctrl_pkg::ANGLE_MAPPING
					: flight_ctrl_pkg::ANGLE_WAITING;
			flight_ctrl_pkg::ANGLE_MAPPING:
				next_state = flight_ctrl_pkg::ANGLE_SCALING;
			flight_ctrl_pkg::ANGLE_SCALING:
				next_state = flight_ctrl_pkg::ANGLE_LIMITING;
			flight_ctrl_pkg::ANGLE_LIMITING:
				next_state = flight_ctrl_pkg::ANGLE_COMPLETE;
			default:
				next_state = flight_ctrl_pkg::ANGLE_WAITING;
		endcase
	end

	// busy through the three working states
	assign active = (state == flight_ctrl_pkg::ANGLE_MAPPING) ||
		(state == flight_ctrl_pkg::ANGLE_SCALING) ||
		(state == flight_ctrl_pkg::ANGLE_LIMITING);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			mapped_throttle <= '0;
			mapped_yaw <= '0;
			mapped_pitch <= '0;
			mapped_roll <= '0;
			scaled_throttle <= '0;
			scaled_yaw <= '0;
			scaled_pitch <= '0;
			scaled_roll <= '0;
			throttle_rate <= '0;
			yaw_rate <= '0;
			pitch_rate <= '0;
			roll_rate <= '0;
			pitch_angle_error <= '0;
			roll_angle_error <= '0;
			complete <= 1'b0;
		end else begin
			// one cycle pulse after the complete state
			complete <= (state == flight_ctrl_pkg::ANGLE_COMPLETE);

			if (state == flight_ctrl_pkg::ANGLE_MAPPING) begin
				// throttle stays positive, the others are centred on the offset
				mapped_throttle <= map_rec(throttle_target);
				mapped_yaw <= map_rec(yaw_target) - flight_ctrl_pkg::fixed_t'(`FC_MAP_OFFSET);
				// angle error is target minus measured angle
				mapped_pitch <= map_rec(pitch_target)
					- flight_ctrl_pkg::fixed_t'(`FC_MAP_OFFSET) - pitch_actual;
				mapped_roll <= map_rec(roll_target)
					- flight_ctrl_pkg::fixed_t'(`FC_MAP_OFFSET) - roll_actual;
			end

			if (state == flight_ctrl_pkg::ANGLE_SCALING) begin
				// sign extend before the shift so nothing is lost
				scaled_throttle <= scale_t'(mapped_throttle) <<< `FC_THROTTLE_SHIFT;
				scaled_yaw <= scale_t'(mapped_yaw) <<< `FC_YAW_SHIFT;
				scaled_pitch <= scale_t'(mapped_pitch) <<< `FC_PITCH_SHIFT;
				scaled_roll <= scale_t'(mapped_roll) <<< `FC_ROLL_SHIFT;
			end

			if (state == flight_ctrl_pkg::ANGLE_LIMITING) begin
				throttle_rate <= sat(scaled_throttle, scale_t'(0), scale_t'(`FC_THROTTLE_MAX));
				yaw_rate <= sat(scaled_yaw, scale_t'(-`FC_RATE_MAX), scale_t'(`FC_RATE_MAX));
				pitch_rate <= sat(scaled_pitch, scale_t'(-`FC_RATE_MAX), scale_t'(`FC_RATE_MAX));
				roll_rate <= sat(scaled_roll, scale_t'(-`FC_RATE_MAX), scale_t'(`FC_RATE_MAX));
				// raw unscaled errors for telemetry
				pitch_angle_error <= mapped_pitch;
				roll_angle_error <= mapped_roll;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/gyro_rate_filter.sv
`timescale 1ns/100ps
`default_nettype none

`include "flight_ctrl_cfg.svh"

module gyro_rate_filter (
	input wire us_clk,
	input wire resetn,
	input wire gyro_valid,
	input wire flight_ctrl_pkg::fixed_t gyro_yaw,
	input wire flight_ctrl_pkg::fixed_t gyro_pitch,
	input wire flight_ctrl_pkg::fixed_t gyro_roll,
	output flight_ctrl_pkg::fixed_t yaw_rate_avg,
	output flight_ctrl_pkg::fixed_t pitch_rate_avg,
	output flight_ctrl_pkg::fixed_t roll_rate_avg
);

	localparam int DEPTH = 1 << `FC_GYRO_DEPTH_LOG2;
	localparam int SUM_W = `FC_DATA_WIDTH + `FC_GYRO_DEPTH_LOG2;
	localparam int AXES = 3;

	typedef logic signed [SUM_W-1:0] sum_t;

	// axis order is yaw, pitch, roll
	flight_ctrl_pkg::fixed_t sample [AXES];
	flight_ctrl_pkg::fixed_t avg [AXES];
	flight_ctrl_pkg::fixed_t hist [AXES][DEPTH];
	sum_t sum [AXES];
	sum_t sum_next [AXES];

	// slot of the oldest sample, overwritten on the next strobe
	logic [`FC_GYRO_DEPTH_LOG2-1:0] wr_ptr;

	assign sample[0] = gyro_yaw;
	assign sample[1] = gyro_pitch;
	assign sample[2] = gyro_roll;

	assign yaw_rate_avg = avg[0];
	assign pitch_rate_avg = avg[1];
	assign roll_rate_avg = avg[2];

	// running sum, newest in and oldest out
	always_comb begin
		for (int a = 0; a < AXES; a++) begin
			sum_next[a] = sum[a] + sum_t'(sample[a]) - sum_t'(hist[a][wr_ptr]);
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			for (int a = 0; a < AXES; a++) begin
				sum[a] <= '0;
				avg[a] <= '0;
				for (int d = 0; d < DEPTH; d++) begin
					hist[a][d] <= '0;
				end
			end
		end else if (gyro_valid) begin
			wr_ptr <= wr_ptr + 1'b1;
			for (int a = 0; a < AXES; a++) begin
				hist[a][wr_ptr] <= sample[a];
				sum[a] <= sum_next[a];
				// divide by the depth, always fits back into the word
				avg[a] <= flight_ctrl_pkg::fixed_t'(sum_next[a] >>> `FC_GYRO_DEPTH_LOG2);
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rate_mixer.sv
`timescale 1ns/100ps
`default_nettype none

`include "flight_ctrl_cfg.svh"

module rate_mixer (
	input wire us_clk,
	input wire resetn,
	input wire complete,
	input wire flight_ctrl_pkg::fixed_t throttle_rate,
	input wire flight_ctrl_pkg::fixed_t yaw_rate,
	input wire flight_ctrl_pkg::fixed_t pitch_rate,
	input wire flight_ctrl_pkg::fixed_t roll_rate,
	input wire flight_ctrl_pkg::fixed_t yaw_rate_avg,
	input wire flight_ctrl_pkg::fixed_t pitch_rate_avg,
	input wire flight_ctrl_pkg::fixed_t roll_rate_avg,
	output flight_ctrl_pkg::fixed_t motor_0,
	output flight_ctrl_pkg::fixed_t motor_1,
	output flight_ctrl_pkg::fixed_t motor_2,
	output flight_ctrl_pkg::fixed_t motor_3,
	output logic motor_valid
);

	// one extra bit for the difference of two words
	localparam int ERR_W = `FC_DATA_WIDTH + 1;
	// throttle plus three clamped errors
	localparam int MIX_W = `FC_DATA_WIDTH + 3;

	typedef logic signed [ERR_W-1:0] err_t;
	typedef logic signed [MIX_W-1:0] mix_t;

	err_t yaw_err, pitch_err, roll_err;
	mix_t thr_w, yaw_w, pitch_w, roll_w;
	mix_t mix_0, mix_1, mix_2, mix_3;

	// symmetric clamp of one axis error
	function automatic err_t clamp_err(input err_t v);
		if (v > err_t'(`FC_RATE_ERR_MAX))
			return err_t'(`FC_RATE_ERR_MAX);
		else if (v < err_t'(-`FC_RATE_ERR_MAX))
			return err_t'(-`FC_RATE_ERR_MAX);
		else
			return v;
	endfunction

	// motors never run backwards
	function automatic flight_ctrl_pkg::fixed_t clamp_motor(input mix_t v);
		if (v > mix_t'(`FC_MOTOR_MAX))
			return flight_ctrl_pkg::fixed_t'(`FC_MOTOR_MAX);
		else if (v < mix_t'(0))
			return '0;
		else
			return flight_ctrl_pkg::fixed_t'(v);
	endfunction

	// target minus measured rate per axis
	always_comb begin
		yaw_err = clamp_err(err_t'(yaw_rate) - err_t'(yaw_rate_avg));
		pitch_err = clamp_err(err_t'(pitch_rate) - err_t'(pitch_rate_avg));
		roll_err = clamp_err(err_t'(roll_rate) - err_t'(roll_rate_avg));
	end

	// widen before mixing
	assign thr_w = mix_t'(throttle_rate);
	assign yaw_w = mix_t'(yaw_err);
	assign pitch_w = mix_t'(pitch_err);
	assign roll_w = mix_t'(roll_err);

	// quad-X layout
	// motors 0 and 2 spin one way, 1 and 3 the other
	// front pair takes positive pitch, left pair positive roll
	assign mix_0 = thr_w + pitch_w + roll_w - yaw_w;
	assign mix_1 = thr_w + pitch_w - roll_w + yaw_w;
	assign mix_2 = thr_w - pitch_w - roll_w - yaw_w;
	assign mix_3 = thr_w - pitch_w + roll_w + yaw_w;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motor_0 <= '0;
			motor_1 <= '0;
			motor_2 <= '0;
			motor_3 <= '0;
			motor_valid <= 1'b0;
		end else begin
			motor_valid <= complete;
			// hold the last command between updates
			if (complete) begin
				motor_0 <= clamp_motor(mix_0);
				motor_1 <= clamp_motor(mix_1);
				motor_2 <= clamp_motor(mix_2);
				motor_3 <= clamp_motor(mix_3);
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/flight_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "flight_ctrl_cfg.svh"

module flight_ctrl_top (
	input wire us_clk,
	input wire resetn,
	input wire start,
	input wire [`FC_REC_WIDTH-1:0] throttle_target,
	input wire [`FC_REC_WIDTH-1:0] yaw_target,
	input wire [`FC_REC_WIDTH-1:0] pitch_target,
	input wire [`FC_REC_WIDTH-1:0] roll_target,
	input wire flight_ctrl_pkg::fixed_t pitch_actual,
	input wire flight_ctrl_pkg::fixed_t roll_actual,
	input wire gyro_valid,
	input wire flight_ctrl_pkg::fixed_t gyro_yaw,
	input wire flight_ctrl_pkg::fixed_t gyro_pitch,
	input wire flight_ctrl_pkg::fixed_t gyro_roll,
	output flight_ctrl_pkg::fixed_t motor_0,
	output flight_ctrl_pkg::fixed_t motor_1,
	output flight_ctrl_pkg::fixed_t motor_2,
	output flight_ctrl_pkg::fixed_t motor_3,
	output logic motor_valid,
	output logic active,
	output flight_ctrl_pkg::fixed_t pitch_angle_error,
	output flight_ctrl_pkg::fixed_t roll_angle_error
);

	// rate targets from the angle loop
	flight_ctrl_pkg::fixed_t throttle_rate, yaw_rate, pitch_rate, roll_rate;
	logic complete;

	// smoothed gyro rates
	flight_ctrl_pkg::fixed_t yaw_rate_avg, pitch_rate_avg, roll_rate_avg;

	angle_controller u_angle_controller (
		.us_clk(us_clk),
		.resetn(resetn),
		.start(start),
		.throttle_target(throttle_target),
		.yaw_target(yaw_target),
		.pitch_target(pitch_target),
		.roll_target(roll_target),
		.pitch_actual(pitch_actual),
		.roll_actual(roll_actual),
		.throttle_rate(throttle_rate),
		.yaw_rate(yaw_rate),
		.pitch_rate(pitch_rate),
		.roll_rate(roll_rate),
		.pitch_angle_error(pitch_angle_error),
		.roll_angle_error(roll_angle_error),
		.active(active),
		.complete(complete)
	);

	gyro_rate_filter u_gyro_rate_filter (
		.us_clk(us_clk),
		.resetn(resetn),
		.gyro_valid(gyro_valid),
		.gyro_yaw(gyro_yaw),
		.gyro_pitch(gyro_pitch),
		.gyro_roll(gyro_roll),
		.yaw_rate_avg(yaw_rate_avg),
		.pitch_rate_avg(pitch_rate_avg),
		.roll_rate_avg(roll_rate_avg)
	);

	// mixes on the complete pulse
	rate_mixer u_rate_mixer (
		.us_clk(us_clk),
		.resetn(resetn),
		.complete(complete),
		.throttle_rate(throttle_rate),
		.yaw_rate(yaw_rate),
		.pitch_rate(pitch_rate),
		.roll_rate(roll_rate),
		.yaw_rate_avg(yaw_rate_avg),
		.pitch_rate_avg(pitch_rate_avg),
		.roll_rate_avg(roll_rate_avg),
		.motor_0(motor_0),
		.motor_1(motor_1),
		.motor_2(motor_2),
		.motor_3(motor_3),
		.motor_valid(motor_valid)
	);

endmodule

`default_nettype wire

//--- sim/tb_flight_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "flight_ctrl_cfg.svh"

module tb_flight_ctrl;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 10;
	localparam int N_BUSY = 10;
	localparam int N_RANDOM = 60;
	localparam int N_GYRO = 40;
	localparam int N_EXTREME = 5;
	// the reset check counts as one item
	localparam int N_ITEMS = 1 + N_BUSY + N_RANDOM + N_GYRO + N_EXTREME;
	localparam int WATCHDOG_NS = (N_ITEMS * 20 + RESET_CYCLES) * CLK_PERIOD;
	// clock edges from the edge that takes start to motor_valid
	localparam int MOTOR_LATENCY = 5;
	localparam int WAIT_LIMIT = 16;
	localparam int GYRO_DEPTH = 1 << `FC_GYRO_DEPTH_LOG2;

	typedef logic [`FC_REC_WIDTH-1:0] rec_t;

	logic us_clk;
	logic resetn;
	logic start;
	rec_t throttle_target, yaw_target, pitch_target, roll_target;
	flight_ctrl_pkg::fixed_t pitch_actual, roll_actual;
	logic gyro_valid;
	flight_ctrl_pkg::fixed_t gyro_yaw, gyro_pitch, gyro_roll;
	flight_ctrl_pkg::fixed_t motor_0, motor_1, motor_2, motor_3;
	logic motor_valid;
	logic active;
	flight_ctrl_pkg::fixed_t pitch_angle_error, roll_angle_error;

	int seed;
	int checks;
	int errors;
	// model gyro history, rows are yaw, pitch, roll
	int gyro_hist [3][GYRO_DEPTH];
	int gyro_slot;
	// throttle, yaw, pitch, roll, pitch angle, roll angle
	int extremes [N_EXTREME][6] = '{
		'{0, 0, 0, 0, 0, 0},
		'{255, 0, 255, 255, -32000, -32000},
		'{0, 255, 0, 0, 32000, 32000},
		'{255, 255, 255, 0, 32000, -32000},
		'{255, 128, 128, 128, 0, 0}
	};

	flight_ctrl_top DUT (.*);

	always #(CLK_PERIOD / 2) us_clk = ~us_clk;

	task automatic compare(input string what, input integer actual, input integer expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	function automatic int limit(input int v, input int lo, input int hi);
		if (v > hi)
			return hi;
		if (v < lo)
			return lo;
		return v;
	endfunction

	// mean of the last four model samples on one axis
	function automatic int gyro_avg(input int axis);
		int sum;
		sum = 0;
		for (int d = 0; d < GYRO_DEPTH; d++)
			sum += gyro_hist[axis][d];
		return sum >>> `FC_GYRO_DEPTH_LOG2;
	endfunction

	function automatic int rand_rec();
		return $random(seed) & ((1 << `FC_REC_WIDTH) - 1);
	endfunction

	// spans clamped and unclamped errors
	function automatic int rand_angle();
		return $random(seed) % 1200;
	endfunction

	// one-cycle gyro strobe, model history follows
	task automatic send_gyro(input int y, input int p, input int r);
		gyro_valid = 1'b1;
		gyro_yaw = flight_ctrl_pkg::fixed_t'(y);
		gyro_pitch = flight_ctrl_pkg::fixed_t'(p);
		gyro_roll = flight_ctrl_pkg::fixed_t'(r);
		gyro_hist[0][gyro_slot] = y;
		gyro_hist[1][gyro_slot] = p;
		gyro_hist[2][gyro_slot] = r;
		gyro_slot = (gyro_slot + 1) % GYRO_DEPTH;
		@(negedge us_clk);
		gyro_valid = 1'b0;
	endtask

	// one start through to motor_valid, checked against the model
	task automatic run_command(input int thr, input int yaw, input int pit, input int rol,
			input int pa, input int ra, input bit busy_start);
		int t, y, p, r, pe, re;
		int ey, ep, er;
		int m [4];
		int cycles;
		bit seen;
		t = limit((thr * 4) <<< `FC_THROTTLE_SHIFT, 0, `FC_THROTTLE_MAX);
		y = limit((yaw * 4 - `FC_MAP_OFFSET) <<< `FC_YAW_SHIFT, -`FC_RATE_MAX, `FC_RATE_MAX);
		// angle errors stay unscaled
		pe = pit * 4 - `FC_MAP_OFFSET - pa;
		re = rol * 4 - `FC_MAP_OFFSET - ra;
		p = limit(pe <<< `FC_PITCH_SHIFT, -`FC_RATE_MAX, `FC_RATE_MAX);
		r = limit(re <<< `FC_ROLL_SHIFT, -`FC_RATE_MAX, `FC_RATE_MAX);
		// rate errors against filtered gyro
		ey = limit(y - gyro_avg(0), -`FC_RATE_ERR_MAX, `FC_RATE_ERR_MAX);
		ep = limit(p - gyro_avg(1), -`FC_RATE_ERR_MAX, `FC_RATE_ERR_MAX);
		er = limit(r - gyro_avg(2), -`FC_RATE_ERR_MAX, `FC_RATE_ERR_MAX);
		// quad-X mix
		m[0] = limit(t + ep + er - ey, 0, `FC_MOTOR_MAX);
		m[1] = limit(t + ep - er + ey, 0, `FC_MOTOR_MAX);
		m[2] = limit(t - ep - er - ey, 0, `FC_MOTOR_MAX);
		m[3] = limit(t - ep + er + ey, 0, `FC_MOTOR_MAX);
		throttle_target = rec_t'(thr);
		yaw_target = rec_t'(yaw);
		pitch_target = rec_t'(pit);
		roll_target = rec_t'(rol);
		pitch_actual = flight_ctrl_pkg::fixed_t'(pa);
		roll_actual = flight_ctrl_pkg::fixed_t'(ra);
		start = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < WAIT_LIMIT) begin
			@(negedge us_clk);
			cycles++;
			seen = motor_valid;
			// busy for the first three cycles after start is taken
			if (!seen)
				compare("active", 32'(active), (cycles <= 3) ? 1 : 0);
			// second start lands while the controller is busy
			start = busy_start && (cycles == 2);
		end
		if (!seen) begin
			errors++;
			$display("motor_valid did not arrive within %0d cycles of start", WAIT_LIMIT);
		end else begin
			compare("edges from start to motor_valid", cycles - 1, MOTOR_LATENCY);
			compare("pitch_angle_error", 32'(pitch_angle_error), pe);
			compare("roll_angle_error", 32'(roll_angle_error), re);
			compare("motor_0", 32'(motor_0), m[0]);
			compare("motor_1", 32'(motor_1), m[1]);
			compare("motor_2", 32'(motor_2), m[2]);
			compare("motor_3", 32'(motor_3), m[3]);
		end
		// single pulse, and no extra one from an ignored start
		repeat (4) begin
			@(negedge us_clk);
			compare("motor_valid after the pulse", 32'(motor_valid), 0);
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		$display("test %0d %s finished with %0d errors", num, name, errors - err_before);
	endtask

	initial begin
		int e0;
		us_clk = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		throttle_target = '0;
		yaw_target = '0;
		pitch_target = '0;
		roll_target = '0;
		pitch_actual = '0;
		roll_actual = '0;
		gyro_valid = 1'b0;
		gyro_yaw = '0;
		gyro_pitch = '0;
		gyro_roll = '0;
		seed = 32'hf3c3afaf;
		checks = 0;
		errors = 0;
		gyro_slot = 0;
		foreach (gyro_hist[a, d])
			gyro_hist[a][d] = 0;
		repeat (RESET_CYCLES) @(negedge us_clk);
		resetn = 1'b1;
		@(negedge us_clk);

		e0 = errors;
		compare("active after reset", 32'(active), 0);
		compare("motor_valid after reset", 32'(motor_valid), 0);
		compare("motor_0 after reset", 32'(motor_0), 0);
		compare("motor_1 after reset", 32'(motor_1), 0);
		compare("motor_2 after reset", 32'(motor_2), 0);
		compare("motor_3 after reset", 32'(motor_3), 0);
		compare("pitch_angle_error after reset", 32'(pitch_angle_error), 0);
		compare("roll_angle_error after reset", 32'(roll_angle_error), 0);
		report_test(1, "reset values", e0);

		e0 = errors;
		repeat (N_BUSY)
			run_command(rand_rec(), rand_rec(), rand_rec(), rand_rec(), rand_angle(),
				rand_angle(), 1'b1);
		report_test(2, "latency and busy start", e0);

		e0 = errors;
		repeat (N_RANDOM)
			run_command(rand_rec(), rand_rec(), rand_rec(), rand_rec(), rand_angle(),
				rand_angle(), 1'b0);
		report_test(3, "random targets without gyro", e0);

		e0 = errors;
		for (int i = 0; i < N_GYRO; i++) begin
			// one to four strobes before each command
			repeat (1 + ($random(seed) & 3))
				send_gyro($random(seed) % 800, $random(seed) % 800, $random(seed) % 800);
			run_command(rand_rec(), rand_rec(), rand_rec(), rand_rec(), rand_angle(),
				rand_angle(), 1'b0);
		end
		report_test(4, "random gyro streams", e0);

		e0 = errors;
		// flush the filter so the extremes see zero rates
		repeat (GYRO_DEPTH)
			send_gyro(0, 0, 0);
		for (int i = 0; i < N_EXTREME; i++)
			run_command(extremes[i][0], extremes[i][1], extremes[i][2], extremes[i][3],
				extremes[i][4], extremes[i][5], 1'b0);
		report_test(5, "directed extremes", e0);

		$display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// budget of twenty cycles per item plus reset
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
rtl/flight_ctrl_pkg.sv
rtl/angle_controller.sv
rtl/gyro_rate_filter.sv
rtl/rate_mixer.sv
rtl/flight_ctrl_top.sv
sim/tb_flight_ctrl.sv

//--- Makefile
# all of these can be overridden on the command line
VERILATOR ?= verilator
TOP ?= tb_flight_ctrl
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?=

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-f $(FILELIST) $(VFLAGS)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
